/* rrag_mem_top.f */
src/mem_stage_pkg.sv
src/stage_if.sv
src/agen_unit.sv
src/rrag_mem_latch.sv
src/mem_access_unit.sv
src/pipe_control.sv
src/rrag_mem_top.sv
tb/rrag_mem_checker.sv
tb/rrag_mem_monitor.sv
tb/rrag_mem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the testbench with Verilator; pass only if the log shows the pass line.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module rrag_mem_tb -f rrag_mem_top.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vrrag_mem_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "STATUS: PASS" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

/* src/agen_unit.sv */
`timescale 1ns/1ns

module agen_unit import mem_stage_pkg::*; (
    input  logic         in_valid,
    input  uop_kind_e    in_kind,
    input  opsize_e      in_opsize,
    input  logic [31:0]  in_seg_base,
    input  logic [31:0]  in_seg_limit,
    input  logic [31:0]  in_base,
    input  logic [31:0]  in_index,
    input  uop_operand_u in_operand,
    input  logic [31:0]  in_store_data,
    input  tag_t         in_tag,
    stage_if.src         agen
);

    logic        is_mem;
    logic [31:0] disp_ext;
    logic [31:0] offset;
    logic [31:0] linear;
    logic [1:0]  size_m1;
    logic [32:0] last_byte;
    logic [2:0]  lane_end;

    assign is_mem   = (in_kind == KIND_LOAD) || (in_kind == KIND_STORE);
    assign disp_ext = {{8{in_operand.mem.disp[23]}}, in_operand.mem.disp};
    assign offset   = in_base + (in_index << in_operand.mem.scale) + disp_ext;
    assign linear   = in_seg_base + offset;

    always_comb begin
        case (in_opsize)
            SIZE_BYTE: size_m1 = 2'd0;
            SIZE_WORD: size_m1 = 2'd1;
            default:   size_m1 = 2'd3;
        endcase
    end

    // One extra bit so an offset near the top of the space still trips the limit.
    assign last_byte = {1'b0, offset} + {31'd0, size_m1};
    assign lane_end  = {1'b0, linear[1:0]} + {1'b0, size_m1};

    always_comb begin
        if (!is_mem) begin
            agen.fault = FAULT_NONE;
        end else if (last_byte > {1'b0, in_seg_limit}) begin
            agen.fault = FAULT_LIMIT;
        end else if (lane_end[2]) begin
            agen.fault = FAULT_ALIGN;
        end else begin
            agen.fault = FAULT_NONE;
        end
    end

    always_comb begin
        case (in_kind)
            KIND_STORE: agen.data = in_store_data;
            KIND_ALU:   agen.data = in_base + in_operand.imm;
            default:    agen.data = 32'd0;
        endcase
    end

    assign agen.valid    = in_valid;
    assign agen.kind     = in_kind;
    assign agen.opsize   = in_opsize;
    assign agen.lin_addr = is_mem ? linear : 32'd0;
    assign agen.tag      = in_tag;

endmodule

/* src/mem_access_unit.sv */
`timescale 1ns/1ns

module mem_access_unit import mem_stage_pkg::*; #(
    parameter int MEM_DEPTH = DEF_MEM_DEPTH
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        advance,
    stage_if.dst        req,
    output logic        res_valid,
    output uop_kind_e   res_kind,
    output fault_e      res_fault,
    output logic [31:0] res_addr,
    output logic [31:0] res_data,
    output tag_t        res_tag
);

    localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

    // Four byte lanes per dword entry.
    logic [3:0][7:0] mem [MEM_DEPTH] = '{default: '0};

    logic [IDX_W-1:0] idx;
    logic [4:0]       shamt;
    logic [3:0]       size_mask;
    logic [3:0]       byte_en;
    logic [31:0]      data_mask;
    logic [31:0]      rd_word;
    logic [31:0]      wr_word;
    logic [31:0]      load_val;
    logic             clean;
    logic             do_store;

    assign idx   = IDX_W'(req.lin_addr[31:2] % MEM_DEPTH);
    assign shamt = {req.lin_addr[1:0], 3'b000};

    always_comb begin
        case (req.opsize)
            SIZE_BYTE: size_mask = 4'b0001;
            SIZE_WORD: size_mask = 4'b0011;
            default:   size_mask = 4'b1111;
        endcase
    end

    assign data_mask = {{8{size_mask[3]}}, {8{size_mask[2]}},
                        {8{size_mask[1]}}, {8{size_mask[0]}}};
    assign byte_en   = size_mask << req.lin_addr[1:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Load extraction and store merge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign rd_word  = mem[idx];
    assign load_val = (rd_word >> shamt) & data_mask;
    assign wr_word  = req.data << shamt;

    assign clean    = req.valid && (req.fault == FAULT_NONE);
    assign do_store = advance && clean && (req.kind == KIND_STORE);

    always_ff @(posedge clk) begin
        if (do_store) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[idx][b] <= wr_word[8*b +: 8];
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else if (advance) begin
            res_valid <= req.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && req.valid) begin
            res_kind  <= req.kind;
            res_fault <= req.fault;
            res_addr  <= req.lin_addr;
            res_tag   <= req.tag;
            if (!clean) begin
                res_data <= 32'd0;
            end else if (req.kind == KIND_LOAD) begin
                res_data <= load_val;
            end else begin
                res_data <= req.data;
            end
        end
    end

endmodule

/* src/mem_stage_pkg.sv */
package mem_stage_pkg;

    typedef enum logic [1:0] {
        KIND_ALU   = 2'd0,
        KIND_LOAD  = 2'd1,
        KIND_STORE = 2'd2
    } uop_kind_e;

    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,
        SIZE_WORD  = 2'd1,
        SIZE_DWORD = 2'd2
    } opsize_e;

    // Limit wins over align when both apply.
    typedef enum logic [1:0] {
        FAULT_NONE  = 2'd0,
        FAULT_LIMIT = 2'd1,
        FAULT_ALIGN = 2'd2
    } fault_e;

    typedef logic [7:0] tag_t;

    // Memory view of the operand word.
    typedef struct packed {
        logic [1:0]         scale;
        logic [5:0]         rsvd;
        logic signed [23:0] disp;
    } mem_operand_t;

    // Alu kinds see an immediate, loads and stores see scale and displacement.
    typedef union packed {
        logic [31:0]  imm;
        mem_operand_t mem;
    } uop_operand_u;

    parameter int DEF_CREDITS   = 2;
    parameter int DEF_MEM_DEPTH = 64;

endpackage

/* src/pipe_control.sv */
`timescale 1ns/1ns

module pipe_control import mem_stage_pkg::*; #(
    parameter int CREDITS = DEF_CREDITS
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           res_valid,
    input  logic                           credit_return,
    output logic                           send,
    output logic                           advance,
    output logic [$clog2(CREDITS + 1)-1:0] credits_left
);

    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [CNT_W-1:0] count;

    // A result leaves only while the consumer has a free slot.
    assign send = res_valid && (count != '0);

    // The output register moves when it is empty or its item is leaving.
    assign advance = !res_valid || send;

    assign credits_left = count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= CNT_W'(CREDITS);
        end else begin
            case ({send, credit_return})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* src/rrag_mem_latch.sv */
`timescale 1ns/1ns

module rrag_mem_latch (
    input  logic clk,
    input  logic reset,
    input  logic ld,
    stage_if.dst din,
    stage_if.src dout
);

    always_ff @(posedge clk) begin
        if (reset) begin
            dout.valid <= 1'b0;
        end else if (ld) begin
            dout.valid <= din.valid;
        end
    end

    // Payload fields.
    always_ff @(posedge clk) begin
        if (ld) begin
            dout.kind     <= din.kind;
            dout.opsize   <= din.opsize;
            dout.lin_addr <= din.lin_addr;
            dout.fault    <= din.fault;
            dout.data     <= din.data;
            dout.tag      <= din.tag;
        end
    end

endmodule

/* src/rrag_mem_top.sv */
`timescale 1ns/1ns

module rrag_mem_top import mem_stage_pkg::*; #(
    parameter int CREDITS   = DEF_CREDITS,
    parameter int MEM_DEPTH = DEF_MEM_DEPTH
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         in_valid,
    input  uop_kind_e    in_kind,
    input  opsize_e      in_opsize,
    input  logic [31:0]  in_seg_base,
    input  logic [31:0]  in_seg_limit,
    input  logic [31:0]  in_base,
    input  logic [31:0]  in_index,
    input  uop_operand_u in_operand,
    input  logic [31:0]  in_store_data,
    input  tag_t         in_tag,
    input  logic         out_credit,
    output logic         in_stall,
    output logic         out_valid,
    output uop_kind_e    out_kind,
    output fault_e       out_fault,
    output logic [31:0]  out_addr,
    output logic [31:0]  out_data,
    output tag_t         out_tag
);

    logic                           res_valid;
    logic                           send;
    logic                           advance;
    logic                           latch_ld;
    logic [$clog2(CREDITS + 1)-1:0] credits_left;

    stage_if agen_to_latch ();
    stage_if latch_to_mem ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    agen_unit agen_unit_i (
        .in_valid      (in_valid),
        .in_kind       (in_kind),
        .in_opsize     (in_opsize),
        .in_seg_base   (in_seg_base),
        .in_seg_limit  (in_seg_limit),
        .in_base       (in_base),
        .in_index      (in_index),
        .in_operand    (in_operand),
        .in_store_data (in_store_data),
        .in_tag        (in_tag),
        .agen          (agen_to_latch)
    );

    rrag_mem_latch rrag_mem_latch_i (
        .clk   (clk),
        .reset (reset),
        .ld    (latch_ld),
        .din   (agen_to_latch),
        .dout  (latch_to_mem)
    );

    mem_access_unit #(
        .MEM_DEPTH (MEM_DEPTH)
    ) mem_access_unit_i (
        .clk       (clk),
        .reset     (reset),
        .advance   (advance),
        .req       (latch_to_mem),
        .res_valid (res_valid),
        .res_kind  (out_kind),
        .res_fault (out_fault),
        .res_addr  (out_addr),
        .res_data  (out_data),
        .res_tag   (out_tag)
    );

    pipe_control #(
        .CREDITS (CREDITS)
    ) pipe_control_i (
        .clk           (clk),
        .reset         (reset),
        .res_valid     (res_valid),
        .credit_return (out_credit),
        .send          (send),
        .advance       (advance),
        .credits_left  (credits_left)
    );

    // Latch refills when its item moves on or when it holds a bubble.
    assign latch_ld  = advance || !latch_to_mem.valid;
    assign in_stall  = latch_to_mem.valid && !latch_ld;
    assign out_valid = send;

endmodule

/* src/stage_if.sv */
`timescale 1ns/1ns

interface stage_if import mem_stage_pkg::*; ();

    logic        valid;
    uop_kind_e   kind;
    opsize_e     opsize;
    logic [31:0] lin_addr;
    fault_e      fault;
    // Store data for stores, result for alu kinds.
    logic [31:0] data;
    tag_t        tag;

    modport src (
        output valid,
        output kind,
        output opsize,
        output lin_addr,
        output fault,
        output data,
        output tag
    );

    modport dst (
        input valid,
        input kind,
        input opsize,
        input lin_addr,
        input fault,
        input data,
        input tag
    );

endinterface

/* tb/rrag_mem_checker.sv */
`timescale 1ns/1ns

module rrag_mem_checker #(
    parameter int CREDITS = 2
) (
    input logic                           clk,
    input logic                           reset,
    input logic                           out_valid,
    input logic [$clog2(CREDITS + 1)-1:0] credits_left,
    input logic                           in_stall,
    input logic                           ld,
    input logic                           lat_valid,
    input logic [31:0]                    lat_addr,
    input logic [31:0]                    lat_data,
    input logic [7:0]                     lat_tag
);

    int fail_count = 0;

    no_send_without_credit: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> credits_left != '0)
        else begin
            $error("out_valid raised with no credit left");
            fail_count++;
        end

    credits_in_range: assert property (@(posedge clk) disable iff (reset)
        int'(credits_left) <= CREDITS)
        else begin
            $error("credit count above its maximum");
            fail_count++;
        end

    no_stall_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !in_stall)
        else begin
            $error("in_stall high right after reset");
            fail_count++;
        end

    latch_holds: assert property (@(posedge clk) disable iff (reset)
        !ld |=> $stable({lat_valid, lat_addr, lat_data, lat_tag}))
        else begin
            $error("latch contents changed while ld was low");
            fail_count++;
        end

endmodule

/* tb/rrag_mem_monitor.sv */
`timescale 1ns/1ns

module rrag_mem_monitor import mem_stage_pkg::*; #(
    parameter int MEM_DEPTH = DEF_MEM_DEPTH
) (
    input logic         clk,
    input logic         reset,
    input logic         check_lat,
    input logic         in_valid,
    input uop_kind_e    in_kind,
    input opsize_e      in_opsize,
    input logic [31:0]  in_seg_base,
    input logic [31:0]  in_seg_limit,
    input logic [31:0]  in_base,
    input logic [31:0]  in_index,
    input uop_operand_u in_operand,
    input logic [31:0]  in_store_data,
    input tag_t         in_tag,
    input logic         in_stall,
    input logic         out_valid,
    input uop_kind_e    out_kind,
    input fault_e       out_fault,
    input logic [31:0]  out_addr,
    input logic [31:0]  out_data,
    input tag_t         out_tag
);

    typedef struct packed {
        uop_kind_e   kind;
        fault_e      fault;
        logic [31:0] addr;
        logic [31:0] data;
        tag_t        tag;
        int          cyc;
        logic        lat;
    } exp_t;

    exp_t       exp_q[$];
    logic [7:0] ref_mem [MEM_DEPTH*4];
    int         cycle = 0;
    int         error_count = 0;
    int         total_results = 0;
    int         test_results = 0;
    int         test_errors = 0;

    initial begin
        for (int i = 0; i < MEM_DEPTH * 4; i++) begin
            ref_mem[i] = 8'd0;
        end
    end

    // Expected result of one micro-op; stores update the model memory.
    function automatic exp_t ref_model(input uop_kind_e k, input opsize_e s,
                                       input logic [31:0] seg_base, input logic [31:0] limit,
                                       input logic [31:0] base, input logic [31:0] index,
                                       input uop_operand_u op, input logic [31:0] sd,
                                       input tag_t t);
        logic [31:0] offset;
        logic [31:0] lin;
        logic [31:0] size;
        logic [32:0] last;
        int          disp;
        int          row;
        exp_t        e;
        e = '{kind: k, fault: FAULT_NONE, addr: 32'd0, data: 32'd0, tag: t,
              cyc: cycle, lat: check_lat};
        if (k == KIND_ALU) begin
            e.data = base + op.imm;
            return e;
        end
        size = (s == SIZE_BYTE) ? 32'd1 : (s == SIZE_WORD) ? 32'd2 : 32'd4;
        disp = op.mem.disp;
        offset = base + (index << op.mem.scale) + disp;
        lin = seg_base + offset;
        e.addr = lin;
        last = {1'b0, offset} + {1'b0, size} - 33'd1;
        if (last > {1'b0, limit}) begin
            e.fault = FAULT_LIMIT;
        end else if ({30'd0, lin[1:0]} + size > 32'd4) begin
            e.fault = FAULT_ALIGN;
        end
        if (e.fault != FAULT_NONE) begin
            return e;
        end
        row = int'((lin >> 2) % MEM_DEPTH);
        for (int b = 0; b < int'(size); b++) begin
            if (k == KIND_STORE) begin
                ref_mem[row*4 + int'(lin[1:0]) + b] = sd[8*b +: 8];
            end else begin
                e.data[8*b +: 8] = ref_mem[row*4 + int'(lin[1:0]) + b];
            end
        end
        if (k == KIND_STORE) begin
            e.data = sd;
        end
        return e;
    endfunction

    task automatic compare_result();
        exp_t e;
        if (exp_q.size() == 0) begin
            $display("Result with tag %0h arrived with no micro-op outstanding", out_tag);
            error_count++;
            test_errors++;
            return;
        end
        e = exp_q.pop_front();
        total_results++;
        test_results++;
        if (out_tag !== e.tag || out_kind !== e.kind || out_fault !== e.fault ||
            out_data !== e.data || (e.kind != KIND_ALU && out_addr !== e.addr)) begin
            $display("error at %0t: tag %0h expected kind %0d fault %0d addr %h data %h",
                     $time, e.tag, e.kind, e.fault, e.addr, e.data);
            $display("error at %0t: tag %0h got kind %0d fault %0d addr %h data %h",
                     $time, out_tag, out_kind, out_fault, out_addr, out_data);
            error_count++;
            test_errors++;
        end else if (e.lat && cycle - e.cyc != 2) begin
            $display("error at %0t: tag %0h latency %0d cycles, expected 2",
                     $time, e.tag, cycle - e.cyc);
            error_count++;
            test_errors++;
        end
    endtask

    // Outputs and inputs are sampled at the edge, before any register moves.
    always @(posedge clk) begin
        if (!reset) begin
            if (out_valid) begin
                compare_result();
            end
            if (in_valid && !in_stall) begin
                exp_q.push_back(ref_model(in_kind, in_opsize, in_seg_base, in_seg_limit,
                                          in_base, in_index, in_operand, in_store_data,
                                          in_tag));
            end
        end
        cycle++;
    end

    function automatic int pending_count();
        return exp_q.size();
    endfunction

    task automatic finish_test(input string name);
        $display("test %s: %0d results, %0d errors", name, test_results, test_errors);
        test_results = 0;
        test_errors = 0;
    endtask

    task automatic print_totals();
        $display("%0d results checked, %0d errors", total_results, error_count);
    endtask

endmodule

/* tb/rrag_mem_tb.sv */
`timescale 1ns/1ns

module rrag_mem_tb import mem_stage_pkg::*; ();

    localparam int CREDITS   = DEF_CREDITS;
    localparam int MEM_DEPTH = DEF_MEM_DEPTH;
    localparam int TIMEOUT   = 200;

    logic         clk;
    logic         reset;
    logic         in_valid;
    uop_kind_e    in_kind;
    opsize_e      in_opsize;
    logic [31:0]  in_seg_base;
    logic [31:0]  in_seg_limit;
    logic [31:0]  in_base;
    logic [31:0]  in_index;
    uop_operand_u in_operand;
    logic [31:0]  in_store_data;
    tag_t         in_tag;
    logic         out_credit;
    logic         in_stall;
    logic         out_valid;
    uop_kind_e    out_kind;
    fault_e       out_fault;
    logic [31:0]  out_addr;
    logic [31:0]  out_data;
    tag_t         out_tag;

    logic         check_lat;
    int           credit_mode;
    int           owed;
    tag_t         next_tag;
    logic [31:0]  stim_seed;
    logic [31:0]  credit_seed;
    logic         aborted;

    rrag_mem_top #(
        .CREDITS   (CREDITS),
        .MEM_DEPTH (MEM_DEPTH)
    ) rrag_mem_top_i (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_kind       (in_kind),
        .in_opsize     (in_opsize),
        .in_seg_base   (in_seg_base),
        .in_seg_limit  (in_seg_limit),
        .in_base       (in_base),
        .in_index      (in_index),
        .in_operand    (in_operand),
        .in_store_data (in_store_data),
        .in_tag        (in_tag),
        .out_credit    (out_credit),
        .in_stall      (in_stall),
        .out_valid     (out_valid),
        .out_kind      (out_kind),
        .out_fault     (out_fault),
        .out_addr      (out_addr),
        .out_data      (out_data),
        .out_tag       (out_tag)
    );

    rrag_mem_monitor #(
        .MEM_DEPTH (MEM_DEPTH)
    ) mon_i (.*);

    bind rrag_mem_top rrag_mem_checker #(.CREDITS(CREDITS)) rrag_mem_checker_i (
        .clk          (clk),
        .reset        (reset),
        .out_valid    (out_valid),
        .credits_left (credits_left),
        .in_stall     (in_stall),
        .ld           (latch_ld),
        .lat_valid    (latch_to_mem.valid),
        .lat_addr     (latch_to_mem.lin_addr),
        .lat_data     (latch_to_mem.data),
        .lat_tag      (latch_to_mem.tag)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [15:0] lcg_step(inout logic [31:0] state);
        state = state * 32'd1103515245 + 32'd12345;
        return state[31:16];
    endfunction

    function automatic uop_operand_u mem_op(input logic [1:0] scale, input int disp);
        uop_operand_u op;
        op.mem.scale = scale;
        op.mem.rsvd  = 6'd0;
        op.mem.disp  = 24'(disp);
        return op;
    endfunction

    // The consumer returns one credit per result, timed by the current mode.
    // Mode 0 returns at once, 1 withholds, 2 returns at random.
    always @(posedge clk) begin
        logic [15:0] r;
        r = lcg_step(credit_seed);
        if (reset) begin
            owed = 0;
            out_credit <= 1'b0;
        end else begin
            if (out_valid) begin
                owed++;
            end
            if (owed > 0 && (credit_mode == 0 || (credit_mode == 2 && r[3]))) begin
                out_credit <= 1'b1;
                owed--;
            end else begin
                out_credit <= 1'b0;
            end
        end
    end

    task automatic abort_run(input string why);
        aborted = 1'b1;
        $display("%s", why);
        mon_i.print_totals();
        $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic drive_uop(input uop_kind_e k, input opsize_e s, input logic [31:0] sb,
                             input logic [31:0] sl, input logic [31:0] b,
                             input logic [31:0] x, input uop_operand_u op,
                             input logic [31:0] sd);
        in_valid      <= 1'b1;
        in_kind       <= k;
        in_opsize     <= s;
        in_seg_base   <= sb;
        in_seg_limit  <= sl;
        in_base       <= b;
        in_index      <= x;
        in_operand    <= op;
        in_store_data <= sd;
        in_tag        <= next_tag;
        next_tag = next_tag + 8'd1;
    endtask

    task automatic wait_accept();
        int n;
        n = 0;
        @(posedge clk);
        while (in_stall && n < TIMEOUT) begin
            n++;
            @(posedge clk);
        end
        if (in_stall) begin
            abort_run("Timed out waiting for the DUT to accept a micro-op");
        end
    endtask

    task automatic issue(input uop_kind_e k, input opsize_e s, input logic [31:0] sb,
                         input logic [31:0] sl, input logic [31:0] b, input logic [31:0] x,
                         input uop_operand_u op, input logic [31:0] sd);
        drive_uop(k, s, sb, sl, b, x, op, sd);
        wait_accept();
    endtask

    task automatic drain(input string name);
        int n;
        n = 0;
        in_valid <= 1'b0;
        @(posedge clk);
        while ((mon_i.pending_count() != 0 || out_valid || owed != 0 || out_credit) &&
               n < TIMEOUT) begin
            n++;
            @(posedge clk);
        end
        if (mon_i.pending_count() != 0) begin
            abort_run("Timed out waiting for outstanding results");
        end else begin
            mon_i.finish_test(name);
        end
    endtask

    task automatic random_uop();
        logic [15:0] r;
        uop_kind_e   k;
        opsize_e     s;
        logic [31:0] sb;
        logic [31:0] sl;
        uop_operand_u op;
        r  = lcg_step(stim_seed);
        k  = uop_kind_e'(2'(r % 16'd3));
        s  = opsize_e'(2'((r >> 4) % 16'd3));
        sl = r[9] ? 32'h0000_FFFF : 32'h0000_0200;
        sb = {12'd0, lcg_step(stim_seed), 4'd0};
        if (k == KIND_ALU) begin
            op.imm = {lcg_step(stim_seed), lcg_step(stim_seed)};
        end else begin
            r  = lcg_step(stim_seed);
            op = mem_op(r[11:10], int'(r[9:0]) - 512);
        end
        r = lcg_step(stim_seed);
        issue(k, s, sb, sl, {22'd0, r[9:0]}, {26'd0, r[15:10]}, op,
              {lcg_step(stim_seed), lcg_step(stim_seed)});
        r = lcg_step(stim_seed);
        if (r[2:0] == 3'd0) begin
            in_valid <= 1'b0;
            @(posedge clk);
        end
    endtask

    initial begin
        int n;
        uop_operand_u op;
        stim_seed     = 32'd25;
        credit_seed   = 32'd25;
        next_tag      = 8'd0;
        aborted       = 1'b0;
        credit_mode   = 0;
        check_lat     = 1'b1;
        reset         = 1'b1;
        in_valid      = 1'b0;
        in_kind       = KIND_ALU;
        in_opsize     = SIZE_BYTE;
        in_seg_base   = 32'd0;
        in_seg_limit  = 32'd0;
        in_base       = 32'd0;
        in_index      = 32'd0;
        in_operand    = '0;
        in_store_data = 32'd0;
        in_tag        = 8'd0;
        out_credit    = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        for (int i = 0; i < 8; i++) begin
            op.imm = {lcg_step(stim_seed), lcg_step(stim_seed)};
            issue(KIND_ALU, SIZE_DWORD, 0, 0, {16'd0, lcg_step(stim_seed)}, 0, op, 0);
        end
        drain("1 alu");

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Stores, then loads of each size
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        issue(KIND_STORE, SIZE_DWORD, 32'h1000, 32'hFFFF, 32'h200, 4, mem_op(2, -8),
              32'hA1B2_C3D4);
        issue(KIND_STORE, SIZE_WORD, 32'h1000, 32'hFFFF, 32'h220, 1, mem_op(1, -16),
              32'hCAFE_5566);
        issue(KIND_STORE, SIZE_BYTE, 32'h1000, 32'hFFFF, 32'h300, 3, mem_op(0, -244),
              32'h0000_0077);
        issue(KIND_LOAD, SIZE_DWORD, 32'h1000, 32'hFFFF, 32'h208, 0, mem_op(0, 0), 0);
        issue(KIND_LOAD, SIZE_WORD, 32'h1000, 32'hFFFF, 32'h20A, 0, mem_op(0, 0), 0);
        issue(KIND_LOAD, SIZE_BYTE, 32'h1000, 32'hFFFF, 32'h20B, 0, mem_op(0, 0), 0);
        issue(KIND_LOAD, SIZE_WORD, 32'h1000, 32'hFFFF, 32'h212, 0, mem_op(0, 0), 0);
        issue(KIND_LOAD, SIZE_DWORD, 32'h1000, 32'hFFFF, 32'h20C, 0, mem_op(0, 0), 0);
        drain("2 store and load");

        issue(KIND_STORE, SIZE_DWORD, 32'h1000, 32'h0FFF, 32'hFFE, 0, mem_op(0, 0),
              32'hDEAD_BEEF);
        issue(KIND_STORE, SIZE_WORD, 32'h1000, 32'h0FFF, 32'h20B, 0, mem_op(0, 0),
              32'h0000_1234);
        issue(KIND_STORE, SIZE_BYTE, 32'h1000, 32'h0FFF, 32'h1000, 0, mem_op(0, 0),
              32'h0000_00EE);
        issue(KIND_LOAD, SIZE_DWORD, 32'h1000, 32'h0FFF, 32'h208, 0, mem_op(0, 0), 0);
        issue(KIND_LOAD, SIZE_DWORD, 32'h1000, 32'h0FFF, 32'hFFC, 0, mem_op(0, 0), 0);
        issue(KIND_LOAD, SIZE_BYTE, 32'h1000, 32'hFFFF, 32'h1000, 0, mem_op(0, 0), 0);
        issue(KIND_LOAD, SIZE_WORD, 32'h1000, 32'h0FFF, 32'hFFF, 0, mem_op(0, 0), 0);
        drain("3 faults");

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Back-pressure
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        credit_mode <= 1;
        check_lat   <= 1'b0;
        for (int i = 0; i < 4; i++) begin
            op.imm = {16'd0, lcg_step(stim_seed)};
            issue(KIND_ALU, SIZE_DWORD, 0, 0, 32'd100 * i, 0, op, 0);
        end
        drive_uop(KIND_ALU, SIZE_DWORD, 0, 0, 32'd7, 0, op, 0);
        n = 0;
        @(posedge clk);
        while (!in_stall && n < TIMEOUT) begin
            n++;
            @(posedge clk);
        end
        if (!in_stall) begin
            abort_run("in_stall never rose while credits were withheld");
        end else if (mon_i.test_results > CREDITS) begin
            abort_run("More results than credits appeared while credits were withheld");
        end
        credit_mode <= 0;
        wait_accept();
        for (int i = 0; i < 3; i++) begin
            op.imm = {16'd0, lcg_step(stim_seed)};
            issue(KIND_ALU, SIZE_DWORD, 0, 0, 32'd9, 0, op, 0);
        end
        drain("4 back-pressure");

        check_lat <= 1'b1;
        for (int i = 0; i < 100; i++) begin
            random_uop();
        end
        check_lat   <= 1'b0;
        credit_mode <= 2;
        for (int i = 0; i < 100; i++) begin
            random_uop();
        end
        credit_mode <= 0;
        drain("5 random mix");

        if (!aborted) begin
            mon_i.print_totals();
            if (mon_i.error_count == 0 &&
                rrag_mem_top_i.rrag_mem_checker_i.fail_count == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
            $finish;
        end
    end

endmodule
